//--- common/gfx_pkg.sv
package gfx_pkg;

    // Signed Q16.16 fixed point
    typedef logic signed [31:0] q16_16_t;

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } color_t;

    typedef struct packed {
        vec3_t  pos;
        color_t color;  // Passed through untouched
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Row-major 3x3 matrix
    typedef struct packed {
        q16_16_t r11;
        q16_16_t r12;
        q16_16_t r13;
        q16_16_t r21;
        q16_16_t r22;
        q16_16_t r23;
        q16_16_t r31;
        q16_16_t r32;
        q16_16_t r33;
    } mat3_t;

    // Q16.16 product, arithmetic shift rounds toward minus infinity
    function automatic q16_16_t q_mul(input q16_16_t a, input q16_16_t b);
        logic signed [63:0] prod;
        prod = a * b;  // Q32.32
        return q16_16_t'(prod >>> 16);
    endfunction

    // Three-term dot product, single shift after a wide accumulate
    function automatic q16_16_t q_dot3(
        input q16_16_t a0, input q16_16_t a1, input q16_16_t a2,
        input q16_16_t b0, input q16_16_t b1, input q16_16_t b2
    );
        logic signed [63:0] p0;
        logic signed [63:0] p1;
        logic signed [63:0] p2;
        logic signed [65:0] acc;
        p0  = a0 * b0;
        p1  = a1 * b1;
        p2  = a2 * b2;
        acc = p0 + p1 + p2;  // Two guard bits cover the carries
        return q16_16_t'(acc >>> 16);
    endfunction

endpackage

//--- hdl/transform_setup.sv
`timescale 1ns/1ps

module transform_setup (
    input  logic            clk,
    input  logic            rst,
    input  logic            transform_load,
    input  gfx_pkg::vec3_t  sin_rot,
    input  gfx_pkg::vec3_t  cos_rot,
    input  gfx_pkg::vec3_t  scale,
    input  gfx_pkg::vec3_t  pos,
    output gfx_pkg::mat3_t  rot_matrix,
    output gfx_pkg::vec3_t  scale_q,
    output gfx_pkg::vec3_t  pos_q
);

    gfx_pkg::q16_16_t sx;
    gfx_pkg::q16_16_t sy;
    gfx_pkg::q16_16_t sz;
    gfx_pkg::q16_16_t cx;
    gfx_pkg::q16_16_t cy;
    gfx_pkg::q16_16_t cz;
    gfx_pkg::q16_16_t czsy;
    gfx_pkg::q16_16_t szsy;
    gfx_pkg::mat3_t   mat_next;

    assign sx = sin_rot.x;
    assign sy = sin_rot.y;
    assign sz = sin_rot.z;
    assign cx = cos_rot.x;
    assign cy = cos_rot.y;
    assign cz = cos_rot.z;

    // Shared partial products of the top two rows
    assign czsy = gfx_pkg::q_mul(cz, sy);
    assign szsy = gfx_pkg::q_mul(sz, sy);

    // R = Rz * Ry * Rx
    always_comb begin
        mat_next.r11 = gfx_pkg::q_mul(cz, cy);
        mat_next.r12 = gfx_pkg::q_mul(czsy, sx) - gfx_pkg::q_mul(sz, cx);
        mat_next.r13 = gfx_pkg::q_mul(czsy, cx) + gfx_pkg::q_mul(sz, sx);
        mat_next.r21 = gfx_pkg::q_mul(sz, cy);
        mat_next.r22 = gfx_pkg::q_mul(szsy, sx) + gfx_pkg::q_mul(cz, cx);
        mat_next.r23 = gfx_pkg::q_mul(szsy, cx) - gfx_pkg::q_mul(cz, sx);
        mat_next.r31 = -sy;
        mat_next.r32 = gfx_pkg::q_mul(cy, sx);
        mat_next.r33 = gfx_pkg::q_mul(cy, cx);
    end

    // Held for every lane until the next load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rot_matrix <= '0;
            scale_q    <= '0;
            pos_q      <= '0;
        end else if (transform_load) begin
            rot_matrix <= mat_next;
            scale_q    <= scale;
            pos_q      <= pos;
        end
    end

endmodule

//--- tri_lane/tri_lane.sv
`timescale 1ns/1ps

module tri_lane (
    input  logic                clk,
    input  logic                rst,
    input  gfx_pkg::mat3_t      rot_matrix,
    input  gfx_pkg::vec3_t      scale,
    input  gfx_pkg::vec3_t      pos,
    input  gfx_pkg::triangle_t  tri_in,
    input  logic                in_valid,
    output logic                in_ready,
    output gfx_pkg::triangle_t  tri_out,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                busy
);

    gfx_pkg::triangle_t tri_q;      // Captured input triangle
    logic               feeding;    // Vertices still entering the rotate stage
    logic [1:0]         feed_cnt;
    gfx_pkg::vertex_t   feed_vtx;
    logic               rot_valid;
    gfx_pkg::vertex_t   rot_vtx;
    logic [1:0]         out_cnt;    // Slot for the next world vertex
    gfx_pkg::vertex_t   world_vtx;

    assign busy     = feeding || rot_valid || out_valid;
    assign in_ready = !busy;  // Only an empty lane takes a triangle

    always_comb begin
        case (feed_cnt)
            2'd0:    feed_vtx = tri_q.v0;
            2'd1:    feed_vtx = tri_q.v1;
            default: feed_vtx = tri_q.v2;
        endcase
    end

    // Scale per axis, then translate
    always_comb begin
        world_vtx.pos.x = gfx_pkg::q_mul(rot_vtx.pos.x, scale.x) + pos.x;
        world_vtx.pos.y = gfx_pkg::q_mul(rot_vtx.pos.y, scale.y) + pos.y;
        world_vtx.pos.z = gfx_pkg::q_mul(rot_vtx.pos.z, scale.z) + pos.z;
        world_vtx.color = rot_vtx.color;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            feeding   <= 1'b0;
            feed_cnt  <= 2'd0;
            rot_valid <= 1'b0;
            out_cnt   <= 2'd0;
            out_valid <= 1'b0;
        end else begin
            rot_valid <= feeding;

            if (in_valid && in_ready) begin
                feeding <= 1'b1;
            end else if (feeding) begin
                if (feed_cnt == 2'd2) begin
                    feeding  <= 1'b0;
                    feed_cnt <= 2'd0;
                end else begin
                    feed_cnt <= feed_cnt + 2'd1;
                end
            end

            if (rot_valid) begin
                out_cnt <= (out_cnt == 2'd2) ? 2'd0 : out_cnt + 2'd1;
            end

            // Third vertex lands, result waits for the collector
            if (rot_valid && out_cnt == 2'd2) begin
                out_valid <= 1'b1;
            end else if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            tri_q <= tri_in;
        end

        // Rotate stage, one matrix row per axis
        if (feeding) begin
            rot_vtx.pos.x <= gfx_pkg::q_dot3(rot_matrix.r11, rot_matrix.r12, rot_matrix.r13,
                                             feed_vtx.pos.x, feed_vtx.pos.y, feed_vtx.pos.z);
            rot_vtx.pos.y <= gfx_pkg::q_dot3(rot_matrix.r21, rot_matrix.r22, rot_matrix.r23,
                                             feed_vtx.pos.x, feed_vtx.pos.y, feed_vtx.pos.z);
            rot_vtx.pos.z <= gfx_pkg::q_dot3(rot_matrix.r31, rot_matrix.r32, rot_matrix.r33,
                                             feed_vtx.pos.x, feed_vtx.pos.y, feed_vtx.pos.z);
            rot_vtx.color <= feed_vtx.color;
        end

        // Never written while a result is held, so tri_out stays stable
        if (rot_valid) begin
            case (out_cnt)
                2'd0:    tri_out.v0 <= world_vtx;
                2'd1:    tri_out.v1 <= world_vtx;
                default: tri_out.v2 <= world_vtx;
            endcase
        end
    end

endmodule

//--- hdl/tri_dispatch.sv
`timescale 1ns/1ps

module tri_dispatch #(
    parameter int NUM_LANES = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    output logic [NUM_LANES-1:0] lane_valid,
    input  logic [NUM_LANES-1:0] lane_ready
);

    // One pointer bit even for a single lane
    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(NUM_LANES - 1);

    logic [PTR_W-1:0] ptr;

    // Only the lane under the pointer sees the triangle
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_valid[i] = in_valid && (ptr == PTR_W'(i));
        end
    end

    assign in_ready = lane_ready[ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (in_valid && in_ready) begin
            ptr <= (ptr == LAST) ? '0 : ptr + 1'b1;  // Fixed rotation keeps order
        end
    end

endmodule

//--- hdl/tri_collect.sv
`timescale 1ns/1ps

module tri_collect #(
    parameter int NUM_LANES = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  gfx_pkg::triangle_t   lane_tri [NUM_LANES],
    input  logic [NUM_LANES-1:0] lane_out_valid,
    output logic [NUM_LANES-1:0] lane_out_ready,
    input  logic [NUM_LANES-1:0] lane_busy,
    output gfx_pkg::triangle_t   tri_out,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 busy
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(NUM_LANES - 1);

    logic [PTR_W-1:0] ptr;  // Head lane, oldest triangle in flight

    assign tri_out   = lane_tri[ptr];
    assign out_valid = lane_out_valid[ptr];
    assign busy      = |lane_busy;

    // Other lanes keep their results until their turn
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_out_ready[i] = out_ready && (ptr == PTR_W'(i));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (out_valid && out_ready) begin
            ptr <= (ptr == LAST) ? '0 : ptr + 1'b1;
        end
    end

endmodule

//--- hdl/world_transform_top.sv
`timescale 1ns/1ps

module world_transform_top #(
    parameter int NUM_LANES = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                transform_load,
    input  gfx_pkg::vec3_t      sin_rot,
    input  gfx_pkg::vec3_t      cos_rot,
    input  gfx_pkg::vec3_t      scale,
    input  gfx_pkg::vec3_t      pos,
    input  gfx_pkg::triangle_t  tri_in,
    input  logic                in_valid,
    output logic                in_ready,
    output gfx_pkg::triangle_t  tri_out,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                busy
);

    gfx_pkg::mat3_t       rot_matrix;
    gfx_pkg::vec3_t       scale_q;
    gfx_pkg::vec3_t       pos_q;
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_ready;
    logic [NUM_LANES-1:0] lane_out_valid;
    logic [NUM_LANES-1:0] lane_out_ready;
    logic [NUM_LANES-1:0] lane_busy;
    gfx_pkg::triangle_t   lane_tri [NUM_LANES];

    transform_setup transform_setup_i (
        .clk            (clk),
        .rst            (rst),
        .transform_load (transform_load),
        .sin_rot        (sin_rot),
        .cos_rot        (cos_rot),
        .scale          (scale),
        .pos            (pos),
        .rot_matrix     (rot_matrix),
        .scale_q        (scale_q),
        .pos_q          (pos_q)
    );

    tri_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) tri_dispatch_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready)
    );

    // Input triangle fans out to every lane, lane_valid picks the taker
    for (genvar i = 0; i < NUM_LANES; i++) begin : lane_g
        tri_lane tri_lane_i (
            .clk        (clk),
            .rst        (rst),
            .rot_matrix (rot_matrix),
            .scale      (scale_q),
            .pos        (pos_q),
            .tri_in     (tri_in),
            .in_valid   (lane_valid[i]),
            .in_ready   (lane_ready[i]),
            .tri_out    (lane_tri[i]),
            .out_valid  (lane_out_valid[i]),
            .out_ready  (lane_out_ready[i]),
            .busy       (lane_busy[i])
        );
    end

    tri_collect #(
        .NUM_LANES (NUM_LANES)
    ) tri_collect_i (
        .clk            (clk),
        .rst            (rst),
        .lane_tri       (lane_tri),
        .lane_out_valid (lane_out_valid),
        .lane_out_ready (lane_out_ready),
        .lane_busy      (lane_busy),
        .tri_out        (tri_out),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .busy           (busy)
    );

endmodule

//--- tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Q16.16 product, exact 64-bit value floored by the arithmetic shift
function automatic gfx_pkg::q16_16_t ref_mul(input gfx_pkg::q16_16_t a,
                                             input gfx_pkg::q16_16_t b);
    logic signed [63:0] wide_a;
    logic signed [63:0] wide_b;
    logic signed [63:0] prod;
    wide_a = a;
    wide_b = b;
    prod   = wide_a * wide_b;
    return gfx_pkg::q16_16_t'(prod >>> 16);
endfunction

// Row times column, all three products summed before the single shift
function automatic gfx_pkg::q16_16_t ref_dot3(input gfx_pkg::vec3_t row,
                                              input gfx_pkg::vec3_t col);
    logic signed [65:0] ax;
    logic signed [65:0] ay;
    logic signed [65:0] az;
    logic signed [65:0] acc;
    ax  = row.x;
    ay  = row.y;
    az  = row.z;
    acc = ax * col.x + ay * col.y + az * col.z;
    return gfx_pkg::q16_16_t'(acc >>> 16);
endfunction

// ZYX rotation, R = Rz * Ry * Rx
function automatic gfx_pkg::mat3_t ref_matrix(input gfx_pkg::vec3_t s, input gfx_pkg::vec3_t c);
    gfx_pkg::mat3_t m;
    m.r11 = ref_mul(c.z, c.y);
    m.r12 = ref_mul(ref_mul(c.z, s.y), s.x) - ref_mul(s.z, c.x);
    m.r13 = ref_mul(ref_mul(c.z, s.y), c.x) + ref_mul(s.z, s.x);
    m.r21 = ref_mul(s.z, c.y);
    m.r22 = ref_mul(ref_mul(s.z, s.y), s.x) + ref_mul(c.z, c.x);
    m.r23 = ref_mul(ref_mul(s.z, s.y), c.x) - ref_mul(c.z, s.x);
    m.r31 = -s.y;
    m.r32 = ref_mul(c.y, s.x);
    m.r33 = ref_mul(c.y, c.x);
    return m;
endfunction

function automatic gfx_pkg::vertex_t ref_vertex(input gfx_pkg::mat3_t m, input gfx_pkg::vec3_t sc,
                                                input gfx_pkg::vec3_t tr,
                                                input gfx_pkg::vertex_t v);
    gfx_pkg::vertex_t w;
    w.pos.x = ref_mul(ref_dot3('{m.r11, m.r12, m.r13}, v.pos), sc.x) + tr.x;
    w.pos.y = ref_mul(ref_dot3('{m.r21, m.r22, m.r23}, v.pos), sc.y) + tr.y;
    w.pos.z = ref_mul(ref_dot3('{m.r31, m.r32, m.r33}, v.pos), sc.z) + tr.z;
    w.color = v.color;  // Color is not transformed
    return w;
endfunction

function automatic gfx_pkg::triangle_t ref_triangle(input gfx_pkg::mat3_t m,
                                                    input gfx_pkg::vec3_t sc,
                                                    input gfx_pkg::vec3_t tr,
                                                    input gfx_pkg::triangle_t t);
    gfx_pkg::triangle_t w;
    w.v0 = ref_vertex(m, sc, tr, t.v0);
    w.v1 = ref_vertex(m, sc, tr, t.v1);
    w.v2 = ref_vertex(m, sc, tr, t.v2);
    return w;
endfunction

`endif

//--- tb/tb_world_transform.sv
`timescale 1ns/1ps

module tb_world_transform;

    localparam int NUM_LANES       = 3;
    localparam int TOTAL_TRI       = 66;  // 3 + 30 + 1 + 12 + 20
    localparam int WATCHDOG_CYCLES = TOTAL_TRI * 20 + 200;
    localparam gfx_pkg::q16_16_t ONE = 32'sh0001_0000;

    logic clk;
    logic rst;
    logic transform_load;
    gfx_pkg::vec3_t sin_rot;
    gfx_pkg::vec3_t cos_rot;
    gfx_pkg::vec3_t scale;
    gfx_pkg::vec3_t pos;
    gfx_pkg::triangle_t tri_in;
    logic in_valid;
    logic in_ready;
    gfx_pkg::triangle_t tri_out;
    logic out_valid;
    logic out_ready;
    logic busy;

    integer seed;
    string  test_name;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     test_err_start;
    int     cycle;
    int     delivered;
    int     lane_hits [NUM_LANES];
    int     acc_cycle_q [$];
    logic   check_latency;
    logic   bp_mode;
    logic   stall_seen;
    logic   prev_hold;
    gfx_pkg::triangle_t exp_in;
    gfx_pkg::triangle_t exp_q [$];  // Scoreboard with the oldest triangle first
    gfx_pkg::triangle_t prev_tri;
    gfx_pkg::triangle_t bp_buf [20];
    gfx_pkg::mat3_t     cur_m;
    gfx_pkg::vec3_t     cur_scale;
    gfx_pkg::vec3_t     cur_pos;
    gfx_pkg::q16_16_t   sin_tab [4];
    gfx_pkg::q16_16_t   cos_tab [4];

    `include "tb_ref_model.svh"

    world_transform_top #(.NUM_LANES(NUM_LANES)) world_transform_top_i (
        .clk(clk), .rst(rst), .transform_load(transform_load),
        .sin_rot(sin_rot), .cos_rot(cos_rot), .scale(scale), .pos(pos),
        .tri_in(tri_in), .in_valid(in_valid), .in_ready(in_ready),
        .tri_out(tri_out), .out_valid(out_valid), .out_ready(out_ready), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    task automatic log_error(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    task automatic show_mismatch(input string what, input string exp_s, input string act_s);
        $display("[FAIL] %s: %s expected %s, actual %s", test_name, what, exp_s, act_s);
        errors++;
    endtask

    // Random sink stalls only during the back-pressure test
    always @(negedge clk) begin
        if (bp_mode) out_ready = 1'($random(seed));
        else out_ready = 1'b1;
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            if (prev_hold)
                assert (out_valid && tri_out === prev_tri)
                else log_error("tri_out or out_valid changed before the triangle was taken");
            prev_hold = out_valid && !out_ready;
            prev_tri  = tri_out;
            if (in_valid && !in_ready) stall_seen = 1'b1;
            if (out_valid && out_ready) begin
                delivered++;
                assert (exp_q.size() > 0) else log_error("a triangle came out that was never sent");
                if (exp_q.size() > 0) begin
                    assert (tri_out === exp_q[0])
                    else show_mismatch("tri_out", $sformatf("%h", exp_q[0]),
                                       $sformatf("%h", tri_out));
                    if (check_latency)
                        assert (cycle - acc_cycle_q[0] == 5)
                        else show_mismatch("latency", "5", $sformatf("%0d", cycle - acc_cycle_q[0]));
                    void'(exp_q.pop_front());
                    void'(acc_cycle_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(exp_in);
                acc_cycle_q.push_back(cycle);
                for (int i = 0; i < NUM_LANES; i++)
                    if (world_transform_top_i.lane_valid[i]) lane_hits[i]++;
            end
        end
    end

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_err_start) begin
            $display("%-18s ok", test_name);
        end else begin
            tests_failed++;
            $display("%-18s %0d error(s)", test_name, errors - test_err_start);
        end
    endtask

    // Called and returns on a falling edge
    task automatic load_transform(input gfx_pkg::vec3_t s, input gfx_pkg::vec3_t c,
                                  input gfx_pkg::vec3_t sc, input gfx_pkg::vec3_t tr);
        sin_rot        = s;
        cos_rot        = c;
        scale          = sc;
        pos            = tr;
        transform_load = 1'b1;
        cur_m          = ref_matrix(s, c);
        cur_scale      = sc;
        cur_pos        = tr;
        @(negedge clk);
        transform_load = 1'b0;
    endtask

    task automatic random_transform();
        gfx_pkg::vec3_t s;
        gfx_pkg::vec3_t c;
        gfx_pkg::vec3_t sc;
        gfx_pkg::vec3_t tr;
        int ix;
        int iy;
        int iz;
        ix = $random(seed) & 3;
        iy = $random(seed) & 3;
        iz = $random(seed) & 3;
        s  = '{sin_tab[ix], sin_tab[iy], sin_tab[iz]};
        c  = '{cos_tab[ix], cos_tab[iy], cos_tab[iz]};
        sc.x = 32'sh0000_8000 + ($random(seed) & 32'h0001_FFFF);  // 0.5 to 2.5
        sc.y = 32'sh0000_8000 + ($random(seed) & 32'h0001_FFFF);
        sc.z = 32'sh0000_8000 + ($random(seed) & 32'h0001_FFFF);
        tr.x = $random(seed) % 32'sh0100_0000;
        tr.y = $random(seed) % 32'sh0100_0000;
        tr.z = $random(seed) % 32'sh0100_0000;
        load_transform(s, c, sc, tr);
    endtask

    task automatic random_vertex(output gfx_pkg::vertex_t v);
        v.pos.x = $random(seed) % 32'sh0100_0000;  // Within +-256.0
        v.pos.y = $random(seed) % 32'sh0100_0000;
        v.pos.z = $random(seed) % 32'sh0100_0000;
        v.color = 24'($random(seed));
    endtask

    task automatic make_tri(output gfx_pkg::triangle_t t);
        random_vertex(t.v0);
        random_vertex(t.v1);
        random_vertex(t.v2);
    endtask

    function automatic gfx_pkg::vertex_t shift_vertex(input gfx_pkg::vertex_t v,
                                                      input gfx_pkg::vec3_t d);
        gfx_pkg::vertex_t w;
        w       = v;
        w.pos.x = v.pos.x + d.x;
        w.pos.y = v.pos.y + d.y;
        w.pos.z = v.pos.z + d.z;
        return w;
    endfunction

    task automatic send_tri(input gfx_pkg::triangle_t t, input gfx_pkg::triangle_t e);
        tri_in   = t;
        exp_in   = e;
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);  // Lane readiness is registered
        @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || busy) @(negedge clk);
    endtask

    initial begin
        gfx_pkg::triangle_t t;
        gfx_pkg::triangle_t e;
        gfx_pkg::vec3_t     trans;
        int                 start_cnt;
        seed = 78;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle = 0;
        delivered = 0;
        rst = 1'b1;
        transform_load = 1'b0;
        sin_rot = '0;
        cos_rot = '0;
        scale = '0;
        pos = '0;
        tri_in = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        bp_mode <= 1'b0;
        check_latency = 1'b0;
        stall_seen = 1'b0;
        prev_hold = 1'b0;
        exp_in = '0;
        for (int i = 0; i < NUM_LANES; i++) lane_hits[i] = 0;
        sin_tab = '{32'sh0, ONE, 32'sh0, -ONE};  // Quarter turns
        cos_tab = '{ONE, 32'sh0, -ONE, 32'sh0};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_state");
        assert (!out_valid) else show_mismatch("out_valid", "0", $sformatf("%b", out_valid));
        assert (!busy) else show_mismatch("busy", "0", $sformatf("%b", busy));
        assert (in_ready) else show_mismatch("in_ready", "1", $sformatf("%b", in_ready));
        finish_test();

        start_test("identity");
        trans = '{32'sh0012_8000, -32'sh0003_4000, 32'sh0100_0000};
        load_transform('0, '{ONE, ONE, ONE}, '{ONE, ONE, ONE}, trans);
        repeat (3) begin
            make_tri(t);
            e = '{shift_vertex(t.v0, trans), shift_vertex(t.v1, trans), shift_vertex(t.v2, trans)};
            send_tri(t, e);
        end
        drain();
        finish_test();

        start_test("random_transforms");
        repeat (5) begin
            random_transform();
            repeat (6) begin
                make_tri(t);
                send_tri(t, ref_triangle(cur_m, cur_scale, cur_pos, t));
            end
            drain();
        end
        finish_test();

        start_test("fixed_latency");
        check_latency = 1'b1;
        make_tri(t);
        send_tri(t, ref_triangle(cur_m, cur_scale, cur_pos, t));
        drain();
        check_latency = 1'b0;
        finish_test();

        start_test("ordering");
        for (int i = 0; i < NUM_LANES; i++) lane_hits[i] = 0;
        repeat (12) begin
            make_tri(t);
            send_tri(t, ref_triangle(cur_m, cur_scale, cur_pos, t));
        end
        drain();
        for (int i = 0; i < NUM_LANES; i++)
            assert (lane_hits[i] == 4)
            else show_mismatch($sformatf("lane %0d count", i), "4", $sformatf("%0d", lane_hits[i]));
        finish_test();

        // Stimulus drawn up front so the stall process owns the seed
        start_test("back_pressure");
        for (int i = 0; i < 20; i++) make_tri(bp_buf[i]);
        start_cnt  = delivered;
        stall_seen = 1'b0;
        bp_mode   <= 1'b1;
        for (int i = 0; i < 20; i++)
            send_tri(bp_buf[i], ref_triangle(cur_m, cur_scale, cur_pos, bp_buf[i]));
        while (exp_q.size() != 0) @(negedge clk);
        bp_mode <= 1'b0;
        @(negedge clk);
        assert (stall_seen) else log_error("in_ready never fell under back-pressure");
        assert (!busy) else show_mismatch("busy after drain", "0", $sformatf("%b", busy));
        assert (delivered - start_cnt == 20)
        else show_mismatch("delivered count", "20", $sformatf("%0d", delivered - start_cnt));
        finish_test();

        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+tb
common/gfx_pkg.sv
hdl/transform_setup.sv
tri_lane/tri_lane.sv
hdl/tri_dispatch.sv
hdl/tri_collect.sv
hdl/world_transform_top.sv
tb/tb_world_transform.sv

//--- Bender.yml
package:
  name: world_transform

sources:
  - common/gfx_pkg.sv
  - hdl/transform_setup.sv
  - tri_lane/tri_lane.sv
  - hdl/tri_dispatch.sv
  - hdl/tri_collect.sv
  - hdl/world_transform_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_world_transform.sv
